// ==== design/boot_rom.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module boot_rom (
    input  logic        clk_i,
    input  logic        rst_n_i,
    periph_bus_if.slave bus
);
    import periph_map_pkg::*;

    localparam int IDX_W = $clog2(`ROM_WORDS);

    data_t            rom_table [`ROM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    logic             new_req;

    // ------------------------------------------------
    // Word table, signature over index
    // ------------------------------------------------
    for (genvar i = 0; i < `ROM_WORDS; i++)
    begin : gen_word
        assign rom_table[i] = {`ROM_SIGNATURE, 16'(i)};
    end

    assign rd_idx  = bus.addr[IDX_W+1:2];  // Byte bits ignored
    assign new_req = bus.req && !bus.ack;

    // Handshake and error flag
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            bus.ack <= 1'b0;
            bus.err <= 1'b0;
        end
        else if (new_req)
        begin
            bus.ack <= 1'b1;
            bus.err <= bus.we;   // Writes are refused
        end
        else if (!bus.req)
        begin
            bus.ack <= 1'b0;
        end
    end

    // Registered read
    always_ff @(posedge clk_i)
    begin
        if (new_req)
        begin
            if (bus.we)
                bus.rdata <= `BAD_DATA;
            else
                bus.rdata <= rom_table[rd_idx];
        end
    end

    // Request fields must hold through the whole handshake
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus.req && $past(bus.req) |-> $stable(bus.addr) && $stable(bus.we))
        else $error("ROM request fields changed while req was high");

endmodule

`default_nettype wire

// ==== design/gpio_regs.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module gpio_regs (
    input  logic              clk_i,
    input  logic              rst_n_i,
    periph_bus_if.slave       bus,
    input  logic [`LED_W-1:0] dip_i,
    output logic [`LED_W-1:0] leds_o
);
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    gpio_reg_e         reg_sel;
    logic [`LED_W-1:0] dip_meta;
    logic [`LED_W-1:0] dip_sync;
    data_t             rd_word;
    logic              new_req;
    logic              led_wr;

    // ------------------------------------------------
    // DIP switch synchronizer
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            dip_meta <= '0;
            dip_sync <= '0;
        end
        else
        begin
            dip_meta <= dip_i;
            dip_sync <= dip_meta;
        end
    end

    // ------------------------------------------------
    // Offset decode
    // ------------------------------------------------
    assign reg_sel = (bus.addr[5:3] == GPIO_LED_DIP) ? GPIO_LED_DIP : GPIO_OTHER;
    assign new_req = bus.req && !bus.ack;
    assign led_wr  = new_req && bus.we && bus.be[0] && (reg_sel == GPIO_LED_DIP);

    always_comb
    begin
        case (reg_sel)
            GPIO_LED_DIP: rd_word = {{(`PERIPH_DATA_W-`LED_W){1'b0}}, dip_sync};
            default:      rd_word = `BAD_DATA;
        endcase
    end

    // Handshake and LED register
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            bus.ack <= 1'b0;
            leds_o  <= '0;
        end
        else
        begin
            if (new_req)
                bus.ack <= 1'b1;
            else if (!bus.req)
                bus.ack <= 1'b0;

            if (led_wr)
                leds_o <= bus.wdata[`LED_W-1:0];  // Low byte only
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (new_req)
            bus.rdata <= rd_word;
    end

    assign bus.err = 1'b0;  // No GPIO access faults

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(bus.ack) |-> bus.req)
        else $error("GPIO ack rose without a request");

endmodule

`default_nettype wire

// ==== design/periph_addr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module periph_addr_decoder (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  periph_map_pkg::addr_t addr_i,
    input  periph_map_pkg::data_t wdata_i,
    input  periph_map_pkg::be_t   be_i,
    output logic                  ack_o,
    output logic                  err_o,
    output periph_map_pkg::data_t rdata_o,
    periph_bus_if.master          rom_bus,
    periph_bus_if.master          gpio_bus
);
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    localparam addr_t ROM_BYTES  = addr_t'(`ROM_WORDS * 4);
    localparam addr_t GPIO_BYTES = addr_t'(`GPIO_BYTES);

    bus_state_e state_q;
    region_e    region_d, region_q;
    addr_t      rom_off, gpio_off;
    addr_t      offset_d, offset_q;
    logic       we_q;
    data_t      wdata_q;
    be_t        be_q;
    logic       slv_ack;
    logic       slv_err;
    data_t      slv_rdata;

    // ------------------------------------------------
    // Region decode, wrap-around subtract keeps it one compare
    // ------------------------------------------------
    always_comb
    begin
        rom_off  = addr_i - addr_t'(`ROM_BASE);
        gpio_off = addr_i - addr_t'(`GPIO_BASE);
        if (rom_off < ROM_BYTES)
        begin
            region_d = REGION_ROM;
            offset_d = rom_off;
        end
        else if (gpio_off < GPIO_BYTES)
        begin
            region_d = REGION_GPIO;
            offset_d = gpio_off;
        end
        else
        begin
            region_d = REGION_NONE;
            offset_d = addr_i;
        end
    end

    assign slv_ack   = (region_q == REGION_ROM) ? rom_bus.ack   : gpio_bus.ack;
    assign slv_err   = (region_q == REGION_ROM) ? rom_bus.err   : gpio_bus.err;
    assign slv_rdata = (region_q == REGION_ROM) ? rom_bus.rdata : gpio_bus.rdata;

    // Both slaves see the same fields, only req is steered
    assign rom_bus.we     = we_q;
    assign rom_bus.addr   = offset_q;
    assign rom_bus.wdata  = wdata_q;
    assign rom_bus.be     = be_q;
    assign gpio_bus.we    = we_q;
    assign gpio_bus.addr  = offset_q;
    assign gpio_bus.wdata = wdata_q;
    assign gpio_bus.be    = be_q;

    always_ff @(posedge clk_i)
    begin
        if (state_q == ST_IDLE && req_i)
        begin
            we_q     <= we_i;
            offset_q <= offset_d;
            wdata_q  <= wdata_i;
            be_q     <= be_i;
        end
    end

    // ------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            state_q      <= ST_IDLE;
            region_q     <= REGION_NONE;
            rom_bus.req  <= 1'b0;
            gpio_bus.req <= 1'b0;
            ack_o        <= 1'b0;
            err_o        <= 1'b0;
            rdata_o      <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (req_i)
                    begin
                        region_q <= region_d;
                        state_q  <= ST_FORWARD;
                    end
                end
                ST_FORWARD:
                begin
                    if (region_q == REGION_NONE)
                    begin
                        ack_o   <= 1'b1;   // Answer locally
                        err_o   <= 1'b1;
                        rdata_o <= `BAD_DATA;
                        state_q <= ST_RESPOND;
                    end
                    else if (!slv_ack) // Previous ack must be seen low first
                    begin
                        rom_bus.req  <= (region_q == REGION_ROM);
                        gpio_bus.req <= (region_q == REGION_GPIO);
                        state_q      <= ST_WAIT_SLAVE;
                    end
                end
                ST_WAIT_SLAVE:
                begin
                    if (slv_ack)
                    begin
                        ack_o   <= 1'b1;
                        err_o   <= slv_err;
                        rdata_o <= slv_rdata;
                        state_q <= ST_RESPOND;
                    end
                end
                ST_RESPOND:
                begin
                    if (!req_i)
                        state_q <= ST_RELEASE;
                end
                ST_RELEASE:
                begin
                    ack_o        <= 1'b0;
                    rom_bus.req  <= 1'b0; // Slave drops its ack one cycle later
                    gpio_bus.req <= 1'b0;
                    state_q      <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------
    // Protocol checks
    // ------------------------------------------------
    // A slave stays busy until its ack has fallen
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((rom_bus.req || rom_bus.ack) && (gpio_bus.req || gpio_bus.ack)))
        else $error("Both slaves busy at once");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i))
        else $error("ack_o rose with no host request pending");

endmodule

`default_nettype wire

// ==== design/periph_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface periph_bus_if;
    import periph_map_pkg::*;

    // Request, owned by the decoder
    logic  req;
    logic  we;
    addr_t addr;    // Offset within the slave region
    data_t wdata;
    be_t   be;

    // Response, owned by the slave
    logic  ack;
    data_t rdata;
    logic  err;

    modport master
    (
        output req, we, addr, wdata, be,
        input  ack, rdata, err
    );

    modport slave
    (
        input  req, we, addr, wdata, be,
        output ack, rdata, err
    );

endinterface

`default_nettype wire

// ==== design/periph_bus_pkg.sv ====
`default_nettype none

package periph_bus_pkg;

    // Decoder FSM
    typedef enum logic [2:0]
    {
        ST_IDLE       = 3'd0,
        ST_FORWARD    = 3'd1, // Request latched, region known
        ST_WAIT_SLAVE = 3'd2,
        ST_RESPOND    = 3'd3, // ack_o held until host drops req_i
        ST_RELEASE    = 3'd4
    } bus_state_e;

    // GPIO register select, offset bits 5:3
    typedef enum logic [2:0]
    {
        GPIO_LED_DIP = 3'd0,
        GPIO_OTHER   = 3'd1   // Any nonzero select
    } gpio_reg_e;

endpackage

`default_nettype wire

// ==== design/periph_map_pkg.sv ====
`default_nettype none
`include "periph_params.svh"

package periph_map_pkg;

    // ------------------------------------------------
    // Bus field types
    // ------------------------------------------------
    typedef logic [`PERIPH_ADDR_W-1:0] addr_t;
    typedef logic [`PERIPH_DATA_W-1:0] data_t;
    typedef logic [`PERIPH_BE_W-1:0]   be_t;    // One bit per byte lane

    // ------------------------------------------------
    // Decoded target of a host request
    // ------------------------------------------------
    typedef enum logic [1:0]
    {
        REGION_ROM  = 2'd0,
        REGION_GPIO = 2'd1,
        REGION_NONE = 2'd2  // Unmapped, answered by the decoder itself
    } region_e;

endpackage

`default_nettype wire

// ==== design/periph_params.svh ====
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// ------------------------------------------------
// Host bus widths
// ------------------------------------------------
`define PERIPH_ADDR_W 32
`define PERIPH_DATA_W 32
`define PERIPH_BE_W   4

// ------------------------------------------------
// Address map
// ------------------------------------------------
`define ROM_BASE   32'h0000_0000
`define ROM_WORDS  64             // 256 byte region
`define GPIO_BASE  32'h0001_0000
`define GPIO_BYTES 64

// GPIO and fixed data words
`define LED_W         8
`define ROM_SIGNATURE 16'hB007    // Upper half of every ROM word
`define BAD_DATA      32'hDEADBEEF

`endif

// ==== design/periph_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module periph_subsystem (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Host side
    input  logic                  req_i,
    input  logic                  we_i,
    input  periph_map_pkg::addr_t addr_i,
    input  periph_map_pkg::data_t wdata_i,
    input  periph_map_pkg::be_t   be_i,
    output logic                  ack_o,
    output periph_map_pkg::data_t rdata_o,
    output logic                  err_o,
    // Board I/O
    input  logic [`LED_W-1:0]     dip_i,
    output logic [`LED_W-1:0]     leds_o
);

    // ------------------------------------------------
    // Slave buses
    // ------------------------------------------------
    periph_bus_if rom_bus ();
    periph_bus_if gpio_bus ();

    periph_addr_decoder u_decoder (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .be_i     (be_i),
        .ack_o    (ack_o),
        .err_o    (err_o),
        .rdata_o  (rdata_o),
        .rom_bus  (rom_bus),
        .gpio_bus (gpio_bus)
    );

    boot_rom u_boot_rom (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (rom_bus)
    );

    gpio_regs u_gpio_regs (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (gpio_bus),
        .dip_i   (dip_i),
        .leds_o  (leds_o)
    );

endmodule

`default_nettype wire

// ==== periph_subsystem.f ====
+incdir+design
design/periph_map_pkg.sv
design/periph_bus_pkg.sv
design/periph_bus_if.sv
design/periph_addr_decoder.sv
design/boot_rom.sv
design/gpio_regs.sv
design/periph_subsystem.sv
sim/tb_periph_subsystem.sv

// ==== sim/tb_periph_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "periph_params.svh"

module tb_periph_subsystem;
    import periph_map_pkg::*;
    import periph_bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 1000;  // ~60 transactions of 10 cycles plus reset

    logic              clk;
    logic              rst_n;
    logic              req;
    logic              we;
    addr_t             addr;
    data_t             wdata;
    be_t               be;
    logic              ack;
    data_t             rdata;
    logic              err;
    logic [`LED_W-1:0] dip;
    logic [`LED_W-1:0] leds;

    // Reference model of the current transaction
    logic              exp_unmapped;
    logic              exp_check_rdata;   // GPIO write data is don't care
    data_t             exp_rdata;
    logic              exp_err;
    logic [`LED_W-1:0] exp_leds;
    logic [`LED_W-1:0] dip_settled;

    logic [31:0] lcg_state;
    int          value_errors;
    int          protocol_errors;
    int          cycle_count;
    bus_state_e  dec_state;

    periph_subsystem u_periph_subsystem (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .be_i    (be),
        .ack_o   (ack),
        .rdata_o (rdata),
        .err_o   (err),
        .dip_i   (dip),
        .leds_o  (leds)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() >> 8) % n;  // Upper bits are the better ones
    endfunction

    function automatic region_e region_of(input addr_t a);
        if ((a - `ROM_BASE) < `ROM_WORDS * 4)
            return REGION_ROM;
        if ((a - `GPIO_BASE) < `GPIO_BYTES)
            return REGION_GPIO;
        return REGION_NONE;
    endfunction

    // ------------------------------------------------
    // Host transactions
    // ------------------------------------------------
    task automatic run_transaction(input logic wr, input addr_t a, input data_t wd,
                                   input be_t b, input int hold);
        region_e rgn;
        addr_t   off;
        rgn             = region_of(a);
        off             = (rgn == REGION_GPIO) ? a - `GPIO_BASE : a - `ROM_BASE;
        exp_unmapped    = (rgn == REGION_NONE);
        exp_check_rdata = !(wr && rgn == REGION_GPIO);
        exp_err         = (rgn == REGION_NONE) || (wr && rgn == REGION_ROM);
        if (rgn == REGION_ROM && !wr)
            exp_rdata = {`ROM_SIGNATURE, 10'd0, off[7:2]};
        else if (rgn == REGION_GPIO && off[5:3] == GPIO_LED_DIP)
            exp_rdata = {{(`PERIPH_DATA_W-`LED_W){1'b0}}, dip_settled};
        else
            exp_rdata = `BAD_DATA;
        if (wr && rgn == REGION_GPIO && off[5:3] == GPIO_LED_DIP && b[0])
            exp_leds = wd[`LED_W-1:0];
        req   = 1'b1;
        we    = wr;
        addr  = a;
        wdata = wd;
        be    = b;
        do
            @(negedge clk);
        while (!ack);
        repeat (hold) @(negedge clk);  // Host back-pressure
        req = 1'b0;
        do
            @(negedge clk);
        while (ack);
    endtask

    task automatic do_read(input addr_t a, input int hold);
        run_transaction(1'b0, a, '0, 4'hF, hold);
    endtask

    task automatic do_write(input addr_t a, input data_t wd, input be_t b, input int hold);
        run_transaction(1'b1, a, wd, b, hold);
    endtask

    task automatic apply_dip(input logic [`LED_W-1:0] value);
        dip = value;
        repeat (3) @(negedge clk);     // Through both sync stages
        dip_settled = value;
    endtask

    // ------------------------------------------------
    // Response checks
    // ------------------------------------------------
    mapped_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) && !exp_unmapped |-> !ack [*4] ##1 ack)
        else
        begin
            protocol_errors++;
            $display("Mapped request was not acknowledged exactly 3 cycles after req_i");
        end

    unmapped_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req) && exp_unmapped |-> !ack [*2] ##1 ack)
        else
        begin
            protocol_errors++;
            $display("Unmapped request was not acknowledged 1 cycle after req_i");
        end

    ack_held: assert property (@(posedge clk) disable iff (!rst_n) ack && req |=> ack)
        else
        begin
            protocol_errors++;
            $display("ack_o dropped while req_i was still high");
        end

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> ack ##1 ack ##1 !ack)
        else
        begin
            protocol_errors++;
            $display("ack_o did not fall one cycle after req_i was sampled low");
        end

    rdata_match: assert property (@(posedge clk) disable iff (!rst_n)
        ack && exp_check_rdata |-> rdata == exp_rdata)
        else
        begin
            value_errors++;
            $display("FAIL rdata_o: expected %h, got %h", exp_rdata, $sampled(rdata));
        end

    err_match: assert property (@(posedge clk) disable iff (!rst_n) ack |-> err == exp_err)
        else
        begin
            value_errors++;
            $display("FAIL err_o: expected %h, got %h", exp_err, $sampled(err));
        end

    rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ack && $past(ack) |-> $stable(rdata))
        else
        begin
            value_errors++;
            $display("FAIL rdata_o: changed to %h while ack_o was held", $sampled(rdata));
        end

    leds_match: assert property (@(posedge clk) disable iff (!rst_n)
        ack || !req |-> leds == exp_leds)
        else
        begin
            value_errors++;
            $display("FAIL leds_o: expected %h, got %h", exp_leds, $sampled(leds));
        end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            dec_state = u_periph_subsystem.u_decoder.state_q;
            $display("Timeout after %0d cycles, decoder stuck in %s", cycle_count,
                     dec_state.name());
            $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    initial
    begin
        int    idx;
        addr_t a;
        lcg_state       = 32'h74e3;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_count     = 0;
        rst_n           = 1'b0;
        req             = 1'b0;
        we              = 1'b0;
        addr            = '0;
        wdata           = '0;
        be              = '0;
        dip             = '0;
        dip_settled     = '0;
        exp_leds        = '0;
        exp_unmapped    = 1'b0;
        exp_check_rdata = 1'b0;
        exp_rdata       = '0;
        exp_err         = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!ack && !err && rdata == '0 && leds == '0)
        else
        begin
            value_errors++;
            $display("FAIL reset: ack_o=%h err_o=%h rdata_o=%h leds_o=%h", ack, err, rdata, leds);
        end

        repeat (16)
        begin
            idx = rand_below(`ROM_WORDS);
            do_read(addr_t'(`ROM_BASE + idx * 4 + rand_below(4)), rand_below(4));
        end

        // Refused ROM writes, table must be untouched
        repeat (4)
        begin
            idx = rand_below(`ROM_WORDS);
            do_write(addr_t'(`ROM_BASE + idx * 4), next_rand(), 4'hF, rand_below(4));
            do_read(addr_t'(`ROM_BASE + idx * 4), 0);
        end

        repeat (8)
            do_write(addr_t'(`GPIO_BASE + rand_below(4)), next_rand(), 4'hF, rand_below(4));
        repeat (3)
            do_write(addr_t'(`GPIO_BASE), next_rand(), 4'hE, rand_below(4));  // No lane 0
        repeat (3)
            do_write(addr_t'(`GPIO_BASE + (int'(GPIO_OTHER) + rand_below(7)) * 8),
                     next_rand(), 4'hF, 0);

        repeat (6)
        begin
            apply_dip(`LED_W'(next_rand()));
            do_read(addr_t'(`GPIO_BASE), rand_below(4));
        end
        repeat (3)
            do_read(addr_t'(`GPIO_BASE + (int'(GPIO_OTHER) + rand_below(7)) * 8),
                    rand_below(4));

        // First byte past each region, then far away
        do_read(addr_t'(`ROM_BASE + `ROM_WORDS * 4), 0);
        do_write(addr_t'(`GPIO_BASE + `GPIO_BYTES), next_rand(), 4'hF, 0);
        repeat (6)
        begin
            a = next_rand() | 32'h8000_0000;
            if (rand_below(2) == 0)
                do_read(a, rand_below(4));
            else
                do_write(a, next_rand(), 4'hF, rand_below(4));
        end

        repeat (3)
            do_write(addr_t'(`GPIO_BASE), next_rand(), 4'h1, 3);  // Long back-pressure

        repeat (4) @(negedge clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
